// ==== sim.f ====
src/f100_pkg.sv
src/f100_arith_unit.sv
src/f100_control.sv
src/f100_cpu.sv
verification/f100_assert.sv
verification/f100_checker.sv
verification/tb_f100.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the F100-L testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_f100 -f sim.f -o tb_f100 \
  > sim.log 2>&1 \
  && ./obj_dir/tb_f100 >> sim.log 2>&1 \
  || echo "build or simulation exited with an error"
cat sim.log 2>/dev/null
grep -q "Simulation finished: PASS" sim.log \
  && echo "run_sim: passed" \
  || { echo "run_sim: failed"; exit 1; }

// ==== verification/tb_f100.sv ====
// ======================================================================
// Testbench for the F100-L core
// Clock, reset, LFSR operands, program builder, memory model,
// reference machine and test sequence
// ======================================================================

`timescale 1ns/100ps

module tb_f100;
  import f100_pkg::*;

  logic     raw_clk;
  logic     button_reset;
  word_t    mem_rdata = '0;
  mem_req_t mem_req;
  logic     halted;
  debug_t   debug;

  word_t prog [0:2047];
  word_t mem [0:2047];
  word_t ref_mem [0:2047];
  word_t wp;

  // Reference machine registers
  word_t m_pc;
  word_t m_a;
  cr_t   m_cr;

  logic [31:0] lfsr_state = 32'h8ee4_be70;
  bit          timed_out = 1'b0;
  word_t       alu_ops [4] = '{16'h9000, 16'ha000, 16'hc000, 16'hd000};
  word_t       shift_modes [3] = '{16'h0000, 16'h0020, 16'h0040};

  f100_cpu #(
    .RESET_PC (16'h0000)
  ) uut (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem_rdata    (mem_rdata),
    .mem_req      (mem_req),
    .halted       (halted),
    .debug        (debug)
  );

  f100_checker chk (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem_req      (mem_req),
    .halted       (halted),
    .debug        (debug)
  );

  initial
  begin
    raw_clk = 1'b0;
    forever #2 raw_clk = ~raw_clk;
  end

  // Program image loads during reset and reads answer one cycle later
  always @(posedge raw_clk)
  begin
    mem_req_t req;
    req = mem_req;
    if (!button_reset)
      mem = prog;
    else if (req.enable && req.write)
      mem[req.address[10:0]] = req.wdata;
    #1;
    if (button_reset && req.enable && !req.write)
      mem_rdata = mem[req.address[10:0]];
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic word_t rand_bits(int n);
    word_t v;
    v = '0;
    for (int b = 0; b < n; b++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[14:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic clear_program();
    for (int i = 0; i < 2048; i++)
      prog[i] = 16'(i * 37) ^ 16'h5ac3;
    wp = '0;
  endtask

  task automatic emit(word_t w);
    prog[wp[10:0]] = w;
    wp = wp + 16'd1;
  endtask

  // Runs one instruction of the reference machine and returns 1 on HALT
  function automatic bit ref_step();
    word_t       ir;
    word_t       ea;
    word_t       d;
    logic [16:0] wide;
    logic [3:0]  cnt;
    ir   = ref_mem[m_pc[10:0]];
    m_pc = m_pc + 16'd1;
    if (ir[15:12] == OP_HALT)
      return 1'b1;
    if (ir[15:12] == OP_SHIFT)
    begin
      cnt = ir[3:0];
      if (ir[7:6] == 2'b01)
        m_a = m_a << cnt;
      else if (ir[5:4] == 2'b10)
        m_a = m_a >> cnt;
      else
        m_a = (m_a >> cnt) | (m_a[15] ? ~(16'hffff >> cnt) : 16'h0000);
      m_cr.s = m_a[15];
      m_cr.z = (m_a == 16'h0000);
      return 1'b0;
    end
    // Zero address field takes the next word as operand
    if (ir[10:0] != 11'd0)
      ea = {5'd0, ir[10:0]};
    else
    begin
      ea   = m_pc;
      m_pc = m_pc + 16'd1;
    end
    d    = ref_mem[ea[10:0]];
    wide = '0;
    case (ir[15:12])
      OP_STO:
      begin
        chk.exp_writes.push_back({ea, m_a});
        ref_mem[ea[10:0]] = m_a;
      end
      OP_LDA:
        m_a = d;
      OP_ADD:
      begin
        wide   = {1'b0, d} + {1'b0, m_a};
        m_cr.v = (d[15] == m_a[15]) && (wide[15] != m_a[15]);
      end
      OP_SUB, OP_CMP:
      begin
        wide   = {1'b0, d} - {1'b0, m_a};
        m_cr.v = (d[15] != m_a[15]) && (wide[15] == m_a[15]);
      end
      OP_AND:
        wide = {1'b0, m_a & d};
      OP_NEQ:
        wide = {1'b0, m_a ^ d};
      OP_JMP:
        m_pc = d;
      default:
      begin
      end
    endcase
    if (ir[15:12] inside {OP_ADD, OP_SUB, OP_CMP, OP_AND, OP_NEQ})
    begin
      m_cr.c = wide[16];
      m_cr.s = wide[15];
      m_cr.z = (wide[15:0] == 16'h0000);
      if (ir[15:12] != OP_CMP)
        m_a = wide[15:0];
    end
    return 1'b0;
  endfunction

  task automatic run_test(string name);
    int cycles;
    int steps;
    bit done;
    if (timed_out)
      return;
    ref_mem = prog;
    m_pc    = 16'h0000;
    m_a     = '0;
    m_cr    = '0;
    chk.exp_writes.delete();
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 200)
    begin
      done = ref_step();
      steps++;
    end
    chk.exp_accum = m_a;
    chk.exp_cr    = m_cr;
    chk.exp_pc    = m_pc;
    chk.test_name = name;
    @(posedge raw_clk);
    #1 button_reset = 1'b0;
    repeat (3) @(posedge raw_clk);
    #1 button_reset = 1'b1;
    cycles = 0;
    while (!chk.finished && cycles < 2000)
    begin
      @(posedge raw_clk);
      #1 cycles++;
    end
    if (!chk.finished)
    begin
      $display("test %s timed out waiting for halted after 2000 cycles", name);
      timed_out = 1'b1;
    end
  endtask

  initial
  begin
    word_t r;
    button_reset = 1'b0;

    clear_program();
    emit(16'h8000);
    emit(rand_bits(16));
    emit(16'h4400);
    emit(16'h1400);
    run_test("lda_sto");

    clear_program();
    for (int k = 0; k < 4; k++)
    begin
      emit(16'h8000);
      emit(rand_bits(16));
      emit(alu_ops[k]);
      emit(rand_bits(16));
      emit(16'h4410 + 16'(k));
    end
    emit(16'h1400);
    run_test("alu");

    // Last pair is equal so Z gets set
    for (int k = 0; k < 4; k++)
    begin
      clear_program();
      r = rand_bits(16);
      emit(16'h8000);
      emit(r);
      emit(16'hb000);
      emit((k == 3) ? r : rand_bits(16));
      emit(16'h1400);
      run_test("cmp");
    end

    clear_program();
    for (int k = 0; k < 3; k++)
    begin
      emit(16'h8000);
      emit(rand_bits(16));
      emit(shift_modes[k] | rand_bits(4));
      emit(16'h4420 + 16'(k));
    end
    emit(16'h1400);
    run_test("shift");

    // Jump over the store at word 4
    clear_program();
    emit(16'h8000);
    emit(rand_bits(16));
    emit(16'hf000);
    emit(16'h0005);
    emit(16'h4500);
    emit(16'h4501);
    emit(16'h1400);
    run_test("jump");

    $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
             chk.tests_run, chk.tests_failed, chk.errors, uut.control_0.asrt_0.failures);
    if (timed_out || chk.errors != 0 || uut.control_0.asrt_0.failures != 0)
      $display("Simulation finished: FAIL");
    else
      $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== verification/f100_checker.sv ====
// ======================================================================
// Bus and debug port checker for the F100-L testbench
// In-order write compare, store slot timing, final pc, accum and cr
// ======================================================================

`timescale 1ns/100ps

module f100_checker (
  input logic               raw_clk,
  input logic               button_reset,
  input f100_pkg::mem_req_t mem_req,
  input logic               halted,
  input f100_pkg::debug_t   debug
);
  import f100_pkg::*;

  // Expected {address, data} writes and final registers for the current test
  logic [31:0] exp_writes [$];
  word_t       exp_accum;
  cr_t         exp_cr;
  word_t       exp_pc;
  string       test_name;

  bit finished = 1'b0;
  int write_idx = 0;
  int since_fetch = 0;
  int test_errors = 0;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  task automatic compare_value(string name, word_t expected, word_t actual);
    if (expected !== actual)
    begin
      $display("[ERROR] %0d ns %s expected %h actual %h", $time, name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic report_problem(string what);
    $display("[ERROR] %0d ns %s", $time, what);
    test_errors++;
  endtask

  always @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      finished    = 1'b0;
      write_idx   = 0;
      test_errors = 0;
    end
    else if (!finished)
    begin
      if (debug.state == FETCH_0)
        since_fetch = 0;
      else
        since_fetch++;
      if (mem_req.enable && mem_req.write)
      begin
        if (write_idx >= exp_writes.size())
          report_problem($sformatf("unexpected write of %h to address %h",
                                   mem_req.wdata, mem_req.address));
        else
        begin
          compare_value("mem_req.address", exp_writes[write_idx][31:16], mem_req.address);
          compare_value("mem_req.wdata", exp_writes[write_idx][15:0], mem_req.wdata);
          // Store pulse sits in EXECUTE five cycles after FETCH_0
          compare_value("store cycle", 16'd5, 16'(since_fetch));
        end
        write_idx++;
      end
      if (halted)
      begin
        compare_value("debug.pc", exp_pc, debug.pc);
        compare_value("debug.accum", exp_accum, debug.accum);
        compare_value("debug.cr", exp_cr, debug.cr);
        if (write_idx < exp_writes.size())
          report_problem($sformatf("%0d expected writes never appeared on the bus",
                                   exp_writes.size() - write_idx));
        tests_run++;
        if (test_errors == 0)
          $display("test %s: ok", test_name);
        else
        begin
          tests_failed++;
          $display("test %s: failed with %0d errors", test_name, test_errors);
        end
        errors += test_errors;
        finished = 1'b1;
      end
    end
  end

endmodule

// ==== verification/f100_assert.sv ====
// ======================================================================
// Concurrent assertions on the F100-L bus strobes
// Write needs enable, single-cycle enable, idle bus while halted
// ======================================================================

`timescale 1ns/100ps

module f100_assert (
  input logic               raw_clk,
  input logic               button_reset,
  input f100_pkg::mem_req_t mem_req,
  input logic               halted
);

  int failures = 0;

  write_has_enable: assert property (@(posedge raw_clk) disable iff (!button_reset)
    mem_req.write |-> mem_req.enable)
  else
  begin
    failures++;
    $error("write strobe seen without enable");
  end

  // Reads and writes are one-cycle pulses
  enable_is_pulse: assert property (@(posedge raw_clk) disable iff (!button_reset)
    mem_req.enable |=> !mem_req.enable)
  else
  begin
    failures++;
    $error("enable held high for two cycles");
  end

  idle_when_halted: assert property (@(posedge raw_clk) disable iff (!button_reset)
    halted |-> !mem_req.enable)
  else
  begin
    failures++;
    $error("bus access while halted");
  end

endmodule

bind f100_control f100_assert asrt_0 (
  .raw_clk      (raw_clk),
  .button_reset (button_reset),
  .mem_req      (mem_req),
  .halted       (halted)
);

// ==== src/f100_cpu.sv ====
// ======================================================================
// F100-L soft core top level
// Control FSM plus accumulator unit, debug record out
// ======================================================================

`timescale 1ns/100ps

module f100_cpu #(
  parameter f100_pkg::word_t RESET_PC = '0
) (
  input  logic               raw_clk,
  input  logic               button_reset,
  input  f100_pkg::word_t    mem_rdata,
  output f100_pkg::mem_req_t mem_req,
  output logic               halted,
  output f100_pkg::debug_t   debug
);
  import f100_pkg::*;

  logic       exec;
  opcode_e    op;
  word_t      operand;
  logic [5:0] shift_ctl;
  word_t      accum;
  cr_t        cr;
  word_t      pc;
  state_e     state;

  f100_control #(
    .RESET_PC (RESET_PC)
  ) control_0 (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem_rdata    (mem_rdata),
    .accum        (accum),
    .mem_req      (mem_req),
    .exec         (exec),
    .op           (op),
    .operand      (operand),
    .shift_ctl    (shift_ctl),
    .halted       (halted),
    .pc           (pc),
    .state        (state)
  );

  f100_arith_unit arith_0 (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .exec         (exec),
    .op           (op),
    .operand      (operand),
    .shift_ctl    (shift_ctl),
    .accum        (accum),
    .cr           (cr)
  );

  // Replaces the LED matrix scan
  assign debug = '{pc: pc, accum: accum, cr: cr, state: state};

endmodule

// ==== src/f100_control.sv ====
// ======================================================================
// Control FSM for the F100-L core
// Fetch, decode of the N and ,D operand forms, operand read,
// execute strobe, store write and jump
// ======================================================================

`timescale 1ns/100ps

module f100_control #(
  parameter f100_pkg::word_t RESET_PC = '0
) (
  input  logic               raw_clk,
  input  logic               button_reset,
  input  f100_pkg::word_t    mem_rdata,
  input  f100_pkg::word_t    accum,
  output f100_pkg::mem_req_t mem_req,
  output logic               exec,
  output f100_pkg::opcode_e  op,
  output f100_pkg::word_t    operand,
  output logic [5:0]         shift_ctl,
  output logic               halted,
  output f100_pkg::word_t    pc,
  output f100_pkg::state_e   state
);
  import f100_pkg::*;

  word_t                   ir;
  word_t                   ea;
  word_t                   data;
  logic [ADDR_N_WIDTH-1:0] addr_n;

  assign addr_n = ir[ADDR_N_WIDTH-1:0];
  assign op     = opcode_e'(ir[15:12]);

  // Sequencing and PC
  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state <= RESET;
      pc    <= RESET_PC;
    end
    else
    begin
      case (state)
        RESET:
          state <= FETCH_0;
        FETCH_0:
        begin
          pc    <= pc + 16'd1;
          state <= FETCH_1;
        end
        FETCH_1:
          state <= DECODE;
        DECODE:
        begin
          case (op)
            OP_SHIFT:
            begin
              // Accumulator target and s_mode 0x only
              if (ir[11:8] == 4'b0000 && !ir[7])
                state <= SHIFT_EXEC;
              else
                state <= ERROR;
            end
            OP_HALT:
            begin
              if (ir[11:10] == 2'b01)
                state <= HALTED;
              else
                state <= ERROR;
            end
            OP_STO, OP_LDA, OP_ADD, OP_SUB, OP_CMP, OP_AND, OP_NEQ, OP_JMP:
            begin
              // Bit 11 selects the pointer forms, not kept here
              if (ir[11])
                state <= ERROR;
              else
              begin
                // Zero field means the operand word follows
                if (addr_n == '0)
                  pc <= pc + 16'd1;
                state <= DATA_0;
              end
            end
            default:
              state <= ERROR;
          endcase
        end
        SHIFT_EXEC:
          state <= FETCH_0;
        DATA_0:
          state <= DATA_1;
        DATA_1:
          state <= EXECUTE;
        EXECUTE:
        begin
          if (op == OP_JMP)
            pc <= data;
          if (op == OP_STO)
            state <= STORE_1;
          else
            state <= FETCH_0;
        end
        STORE_1:
          state <= FETCH_0;
        HALTED:
          state <= HALTED;
        ERROR:
          state <= ERROR;
        default:
          state <= ERROR;
      endcase
    end
  end

  // Instruction, effective address and operand
  always_ff @(posedge raw_clk)
  begin
    if (state == FETCH_1)
      ir <= mem_rdata;
    if (state == DECODE)
      ea <= (addr_n != '0) ? word_t'(addr_n) : pc;
    if (state == DATA_1)
      data <= mem_rdata;
  end

  // Bus strobes are single-cycle pulses decoded from the state
  always_comb
  begin
    mem_req = '0;
    case (state)
      FETCH_0:
      begin
        mem_req.enable  = 1'b1;
        mem_req.address = pc;
      end
      DATA_0:
      begin
        mem_req.enable  = 1'b1;
        mem_req.address = ea;
      end
      EXECUTE:
      begin
        if (op == OP_STO)
        begin
          mem_req.enable  = 1'b1;
          mem_req.write   = 1'b1;
          mem_req.address = ea;
          mem_req.wdata   = accum;
        end
      end
      default:
      begin
      end
    endcase
  end

  assign exec    = (state == EXECUTE) || (state == SHIFT_EXEC);
  assign operand = data;
  assign halted  = (state == HALTED);

  // Left, logical (j_mode 10) and bit count
  assign shift_ctl = {ir[6], ir[5:4] == 2'b10, ir[3:0]};

endmodule

// ==== src/f100_arith_unit.sv ====
// ======================================================================
// Accumulator and condition register of the F100-L core
// Adder, subtractor, logic ops, single-length shifter, C S Z V flags
// ======================================================================

`timescale 1ns/100ps

module f100_arith_unit (
  input  logic              raw_clk,
  input  logic              button_reset,
  input  logic              exec,
  input  f100_pkg::opcode_e op,
  input  f100_pkg::word_t   operand,
  input  logic [5:0]        shift_ctl,
  output f100_pkg::word_t   accum,
  output f100_pkg::cr_t     cr
);
  import f100_pkg::*;

  logic        shift_left;
  logic        shift_logical;
  logic [3:0]  shift_count;
  word_t       shifted;
  logic [16:0] result;
  logic        v_flag;
  logic        write_a;
  logic        set_c;
  logic        set_sz;
  logic        set_v;

  assign shift_left    = shift_ctl[5];
  assign shift_logical = shift_ctl[4];
  assign shift_count   = shift_ctl[3:0];

  always_comb
  begin
    if (shift_left)
      shifted = accum << shift_count;
    else if (shift_logical)
      shifted = accum >> shift_count;
    else
      shifted = word_t'($signed(accum) >>> shift_count);
  end

  // Bit 16 of the result carries C for the add and subtract forms
  always_comb
  begin
    result = '0;
    v_flag = 1'b0;
    case (op)
      OP_LDA:
        result = {1'b0, operand};
      OP_ADD:
      begin
        result = {1'b0, operand} + {1'b0, accum};
        v_flag = (accum[15] == operand[15]) && (result[15] != accum[15]);
      end
      OP_SUB, OP_CMP:
      begin
        // Operand minus accumulator
        result = {1'b0, operand} - {1'b0, accum};
        v_flag = (accum[15] != operand[15]) && (result[15] == accum[15]);
      end
      OP_AND:
        result = {1'b0, accum & operand};
      OP_NEQ:
        result = {1'b0, accum ^ operand};
      OP_SHIFT:
        result = {1'b0, shifted};
      default:
      begin
      end
    endcase
  end

  // Which registers each op touches
  assign write_a = (op == OP_LDA) || (op == OP_ADD) || (op == OP_SUB) ||
                   (op == OP_AND) || (op == OP_NEQ) || (op == OP_SHIFT);
  assign set_v   = (op == OP_ADD) || (op == OP_SUB) || (op == OP_CMP);
  assign set_c   = set_v || (op == OP_AND) || (op == OP_NEQ);
  assign set_sz  = set_c || (op == OP_SHIFT);

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      accum <= '0;
      cr    <= '0;
    end
    else if (exec)
    begin
      if (write_a)
        accum <= result[15:0];
      if (set_c)
        cr.c <= result[16];
      if (set_sz)
      begin
        cr.s <= result[15];
        cr.z <= (result[15:0] == '0);
      end
      if (set_v)
        cr.v <= v_flag;
    end
  end

endmodule

// ==== src/f100_pkg.sv ====
// ======================================================================
// Shared definitions for the F100-L core
// Word type, direct address width, opcode and FSM state enums
// Condition register, memory bus request and debug port records
// ======================================================================

package f100_pkg;

  typedef logic [15:0] word_t;

  // Direct operand field sits in instruction bits 10:0
  localparam int ADDR_N_WIDTH = 11;

  // Top nibble of the instruction word
  typedef enum logic [3:0] {
    OP_SHIFT = 4'h0,
    OP_HALT  = 4'h1,
    OP_STO   = 4'h4,
    OP_LDA   = 4'h8,
    OP_ADD   = 4'h9,
    OP_SUB   = 4'ha,
    OP_CMP   = 4'hb,
    OP_AND   = 4'hc,
    OP_NEQ   = 4'hd,
    OP_JMP   = 4'hf
  } opcode_e;

  typedef enum logic [3:0] {
    RESET,
    FETCH_0,
    FETCH_1,
    DECODE,
    SHIFT_EXEC,
    DATA_0,
    DATA_1,
    EXECUTE,
    STORE_1,
    HALTED,
    ERROR
  } state_e;

  // Bit 6 down to bit 0 follow the F100-L layout
  typedef struct packed {
    logic [8:0] unused;
    logic       f;
    logic       m;
    logic       c;
    logic       s;
    logic       v;
    logic       z;
    logic       i;
  } cr_t;

  typedef struct packed {
    word_t address;
    word_t wdata;
    logic  enable;
    logic  write;
  } mem_req_t;

  typedef struct packed {
    word_t  pc;
    word_t  accum;
    cr_t    cr;
    state_e state;
  } debug_t;

endpackage
